//--- source/ethernet_package.sv
`default_nettype none

package ethernet_package;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;
    typedef logic [10:0] byte_count_t;

    // Source of the next byte on the wire
    typedef enum logic [2:0] {
        select_idle,
        select_preamble,
        select_delimiter,
        select_payload,
        select_pad,
        select_fcs
    } byte_select_t;

    typedef enum logic [2:0] {
        state_idle,
        state_preamble,
        state_delimiter,
        state_payload,
        state_pad,
        state_fcs,
        state_gap
    } transmit_state_t;

    localparam byte_t PREAMBLE_BYTE  = 8'h55;
    localparam byte_t DELIMITER_BYTE = 8'hD5;

    localparam int PREAMBLE_LENGTH    = 7;
    // Payload plus pad, FCS not included
    localparam int MIN_PAYLOAD_LENGTH = 60;
    localparam int FCS_LENGTH         = 4;
    localparam int GAP_LENGTH         = 12;

    localparam crc_t CRC_INITIAL = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- source/payload_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module payload_buffer
    import ethernet_package::*;
#(
    parameter int BUFFER_DEPTH = 256
) (
    input  wire        clock,
    input  wire        reset_n,
    input  wire byte_t write_data,
    input  wire        write_enable,
    input  wire        write_last,
    output logic       buffer_full,
    input  wire        read_enable,
    output byte_t      read_data,
    output logic       read_last,
    output logic       frame_ready
);

    localparam int ADDRESS_WIDTH = $clog2(BUFFER_DEPTH);

    // Bit 8 carries the last flag
    logic [8:0] memory [BUFFER_DEPTH];

    // One extra bit to tell full from empty
    logic [ADDRESS_WIDTH:0] write_pointer;
    logic [ADDRESS_WIDTH:0] read_pointer;
    logic [ADDRESS_WIDTH:0] frame_count;

    logic write_accept;
    logic buffer_empty;
    logic read_pending;
    logic frame_written;
    logic frame_taken;

    assign write_accept  = write_enable && !buffer_full;
    assign buffer_empty  = write_pointer == read_pointer;
    assign buffer_full   = (write_pointer[ADDRESS_WIDTH] != read_pointer[ADDRESS_WIDTH])
        && (write_pointer[ADDRESS_WIDTH-1:0] == read_pointer[ADDRESS_WIDTH-1:0]);

    // A frame leaves the count once its last byte has been read out
    assign frame_written = write_accept && write_last;
    assign frame_taken   = read_pending && read_last;
    assign frame_ready   = frame_count != '0;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (write_accept) begin
            memory[write_pointer[ADDRESS_WIDTH-1:0]] <= {write_last, write_data};
        end
        if (read_enable) begin
            {read_last, read_data} <= memory[read_pointer[ADDRESS_WIDTH-1:0]];
        end
    end

    //////////////////////////////
    // Pointers and frame count
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            frame_count   <= '0;
            read_pending  <= 1'b0;
        end else begin
            if (write_accept) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (read_enable) begin
                read_pointer <= read_pointer + 1'b1;
            end
            read_pending <= read_enable;

            if (frame_written && !frame_taken) begin
                frame_count <= frame_count + 1'b1;
            end else if (frame_taken && !frame_written) begin
                frame_count <= frame_count - 1'b1;
            end
        end
    end

    // Host must honour buffer_full
    no_write_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        !(write_enable && buffer_full))
        else $error("Write attempted while the payload buffer is full");

    // Controller reads only bytes that are stored
    no_read_when_empty: assert property (@(posedge clock) disable iff (!reset_n)
        read_enable |-> !buffer_empty)
        else $error("Read from an empty payload buffer");

endmodule

`default_nettype wire

//--- source/transmit_controller.sv
`timescale 1ns/100ps
`default_nettype none

module transmit_controller
    import ethernet_package::*;
(
    input  wire          clock,
    input  wire          reset_n,
    input  wire          frame_ready,
    input  wire          read_last,
    output logic         read_enable,
    output byte_select_t byte_select,
    output logic         crc_clear
);

    localparam logic [3:0]  PREAMBLE_LAST = 4'(PREAMBLE_LENGTH - 1);
    localparam logic [3:0]  FCS_LAST      = 4'(FCS_LENGTH - 1);
    localparam logic [3:0]  GAP_LAST      = 4'(GAP_LENGTH - 1);
    localparam byte_count_t PAD_LAST      = byte_count_t'(MIN_PAYLOAD_LENGTH - 1);

    transmit_state_t state;

    // Preamble, FCS and gap positions
    logic [3:0] step_count;

    // Payload plus pad bytes sent so far
    byte_count_t byte_count;

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= state_idle;
            step_count <= '0;
            byte_count <= '0;
        end else begin
            case (state)
                state_idle: begin
                    if (frame_ready) begin
                        state <= state_preamble;
                    end
                end

                state_preamble: begin
                    if (step_count == PREAMBLE_LAST) begin
                        step_count <= '0;
                        state      <= state_delimiter;
                    end else begin
                        step_count <= step_count + 1'b1;
                    end
                end

                state_delimiter: begin
                    byte_count <= '0;
                    state      <= state_payload;
                end

                // read_last belongs to the byte presented in this cycle
                state_payload: begin
                    byte_count <= byte_count + 1'b1;
                    if (read_last) begin
                        if (byte_count < PAD_LAST) begin
                            state <= state_pad;
                        end else begin
                            state <= state_fcs;
                        end
                    end
                end

                state_pad: begin
                    byte_count <= byte_count + 1'b1;
                    if (byte_count == PAD_LAST) begin
                        state <= state_fcs;
                    end
                end

                state_fcs: begin
                    if (step_count == FCS_LAST) begin
                        step_count <= '0;
                        state      <= state_gap;
                    end else begin
                        step_count <= step_count + 1'b1;
                    end
                end

                state_gap: begin
                    if (step_count == GAP_LAST) begin
                        step_count <= '0;
                        state      <= state_idle;
                    end else begin
                        step_count <= step_count + 1'b1;
                    end
                end

                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    // First read during the delimiter, then one per payload byte until the last
    assign read_enable = (state == state_delimiter)
        || ((state == state_payload) && !read_last);

    assign crc_clear = state == state_delimiter;

    always_comb begin
        case (state)
            state_preamble:  byte_select = select_preamble;
            state_delimiter: byte_select = select_delimiter;
            state_payload:   byte_select = select_payload;
            state_pad:       byte_select = select_pad;
            state_fcs:       byte_select = select_fcs;
            default:         byte_select = select_idle;
        endcase
    end

    // Reads fetch only a frame that is stored complete
    read_of_stored_frame: assert property (@(posedge clock) disable iff (!reset_n)
        read_enable |-> frame_ready)
        else $error("Payload read issued with no complete frame stored");

endmodule

`default_nettype wire

//--- source/frame_check_sequence_generator.sv
`timescale 1ns/100ps
`default_nettype none

module frame_check_sequence_generator
    import ethernet_package::*;
(
    input  wire        clock,
    input  wire        reset_n,
    input  wire byte_t data,
    input  wire        data_enable,
    input  wire        clear,
    output crc_t       checksum
);

    // IEEE 802.3 generator polynomial, normal form
    localparam crc_t CRC_POLYNOMIAL = 32'h04C1_1DB7;

    byte_t data_reversed;
    crc_t  checksum_next;

    // Ethernet sends each byte least significant bit first
    function automatic crc_t crc_update(crc_t crc, byte_t data_bits);
        crc_t result;
        logic feedback;
        result = crc;
        for (int i = 7; i >= 0; i--) begin
            feedback = result[31] ^ data_bits[i];
            result   = {result[30:0], 1'b0} ^ ({32{feedback}} & CRC_POLYNOMIAL);
        end
        return result;
    endfunction

    assign data_reversed = {<<{data}};

    // Unrolls into one level of XOR terms per register bit
    always_comb begin
        checksum_next = crc_update(checksum, data_reversed);
    end

    //////////////////////////////
    // CRC register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            checksum <= CRC_INITIAL;
        end else if (clear) begin
            checksum <= CRC_INITIAL;
        end else if (data_enable) begin
            checksum <= checksum_next;
        end
    end

    // Clear comes with the delimiter, never with a counted byte
    clear_not_with_data: assert property (@(posedge clock) disable iff (!reset_n)
        clear |-> !data_enable)
        else $error("CRC clear coincides with an enabled byte");

endmodule

`default_nettype wire

//--- source/frame_output_stage.sv
`timescale 1ns/100ps
`default_nettype none

module frame_output_stage
    import ethernet_package::*;
(
    input  wire               clock,
    input  wire               reset_n,
    input  wire byte_select_t byte_select,
    input  wire byte_t        read_data,
    input  wire crc_t         checksum,
    output byte_t             frame_byte,
    output logic              crc_enable,
    output byte_t             tx_data,
    output logic              tx_enable
);

    crc_t  checksum_reversed;
    crc_t  final_fcs;
    crc_t  fcs_shift;
    logic  fcs_started;
    byte_t fcs_byte;

    assign checksum_reversed = {<<{checksum}};
    assign final_fcs         = ~checksum_reversed;

    // First FCS byte straight from the generator, the rest from the shifter
    assign fcs_byte = fcs_started ? fcs_shift[7:0] : final_fcs[7:0];

    always_comb begin
        case (byte_select)
            select_preamble:  frame_byte = PREAMBLE_BYTE;
            select_delimiter: frame_byte = DELIMITER_BYTE;
            select_payload:   frame_byte = read_data;
            select_fcs:       frame_byte = fcs_byte;
            // Pad and idle
            default:          frame_byte = '0;
        endcase
    end

    assign crc_enable = (byte_select == select_payload) || (byte_select == select_pad);

    //////////////////////////////
    // FCS shifter
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            fcs_started <= 1'b0;
        end else begin
            fcs_started <= byte_select == select_fcs;
        end
    end

    always_ff @(posedge clock) begin
        if (byte_select == select_fcs) begin
            if (fcs_started) begin
                fcs_shift <= fcs_shift >> 8;
            end else begin
                fcs_shift <= final_fcs >> 8;
            end
        end
    end

    //////////////////////////////
    // GMII outputs
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            tx_enable <= 1'b0;
        end else begin
            tx_enable <= byte_select != select_idle;
        end
    end

    always_ff @(posedge clock) begin
        tx_data <= frame_byte;
    end

endmodule

`default_nettype wire

//--- source/ethernet_transmitter.sv
`timescale 1ns/100ps
`default_nettype none

module ethernet_transmitter
    import ethernet_package::*;
#(
    parameter int BUFFER_DEPTH = 256
) (
    input  wire        clock,
    input  wire        reset_n,
    input  wire byte_t write_data,
    input  wire        write_enable,
    input  wire        write_last,
    output wire        buffer_full,
    output wire byte_t tx_data,
    output wire        tx_enable
);

    // Buffer to controller
    wire               frame_ready;
    wire               read_enable;
    wire               read_last;
    wire byte_t        read_data;

    // Controller to output stage and generator
    wire byte_select_t byte_select;
    wire               crc_clear;

    // Output stage and generator
    wire byte_t        frame_byte;
    wire               crc_enable;
    wire crc_t         checksum;

    payload_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_payload_buffer (
        .clock        (clock),
        .reset_n      (reset_n),
        .write_data   (write_data),
        .write_enable (write_enable),
        .write_last   (write_last),
        .buffer_full  (buffer_full),
        .read_enable  (read_enable),
        .read_data    (read_data),
        .read_last    (read_last),
        .frame_ready  (frame_ready)
    );

    transmit_controller i_transmit_controller (
        .clock       (clock),
        .reset_n     (reset_n),
        .frame_ready (frame_ready),
        .read_last   (read_last),
        .read_enable (read_enable),
        .byte_select (byte_select),
        .crc_clear   (crc_clear)
    );

    frame_check_sequence_generator i_frame_check_sequence_generator (
        .clock       (clock),
        .reset_n     (reset_n),
        .data        (frame_byte),
        .data_enable (crc_enable),
        .clear       (crc_clear),
        .checksum    (checksum)
    );

    frame_output_stage i_frame_output_stage (
        .clock       (clock),
        .reset_n     (reset_n),
        .byte_select (byte_select),
        .read_data   (read_data),
        .checksum    (checksum),
        .frame_byte  (frame_byte),
        .crc_enable  (crc_enable),
        .tx_data     (tx_data),
        .tx_enable   (tx_enable)
    );

endmodule

`default_nettype wire

//--- test/clock_generator.sv
`timescale 1ns/100ps
`default_nettype none

module clock_generator #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/ethernet_transmitter_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ethernet_transmitter_tb
    import ethernet_package::*;
();

    localparam int BUFFER_DEPTH = 128;
    localparam int CLOCK_PERIOD = 8;
    localparam int MIN_GAP      = 12;

    // Payload bytes over all tests
    localparam int TEST_BYTES      = 20 + 60 + 100 + 30 + 70 + BUFFER_DEPTH;
    localparam int WATCHDOG_CYCLES = 200 * TEST_BYTES;

    typedef byte_t byte_queue_t[$];

    logic  clock;
    logic  reset_n;
    byte_t write_data;
    logic  write_enable;
    logic  write_last;
    logic  buffer_full;
    byte_t tx_data;
    logic  tx_enable;

    int seed;
    int error_count;

    // Captured bursts, all bytes in one queue
    byte_t captured_bytes[$];
    int    burst_lengths[$];
    int    gap_lengths[$];
    int    last_gap;
    logic  burst_active = 1'b0;
    int    burst_length = 0;
    int    idle_length  = 0;

    clock_generator #(
        .PERIOD       (CLOCK_PERIOD),
        .RESET_CYCLES (2)
    ) i_clock_generator (
        .clock   (clock),
        .reset_n (reset_n)
    );

    ethernet_transmitter #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_ethernet_transmitter (
        .clock        (clock),
        .reset_n      (reset_n),
        .write_data   (write_data),
        .write_enable (write_enable),
        .write_last   (write_last),
        .buffer_full  (buffer_full),
        .tx_data      (tx_data),
        .tx_enable    (tx_enable)
    );

    //////////////////////////////
    // Monitor
    //////////////////////////////

    always @(negedge clock) begin
        if (tx_enable) begin
            if (!burst_active) begin
                gap_lengths.push_back(idle_length);
                burst_length = 0;
            end
            burst_active = 1'b1;
            captured_bytes.push_back(tx_data);
            burst_length++;
        end else begin
            if (burst_active) begin
                burst_lengths.push_back(burst_length);
                idle_length = 0;
            end
            burst_active = 1'b0;
            idle_length++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the frames were not all sent within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic byte_queue_t random_payload(input int length);
        byte_queue_t payload;
        for (int i = 0; i < length; i++) begin
            payload.push_back(byte_t'($random(seed)));
        end
        return payload;
    endfunction

    // Bitwise reflected CRC-32, complemented
    function automatic logic [31:0] reference_fcs(input byte_queue_t data);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        foreach (data[i]) begin
            crc = crc ^ {24'h0, data[i]};
            for (int bit_index = 0; bit_index < 8; bit_index++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    task automatic write_frame(input byte_queue_t payload);
        int index;
        index = 0;
        while (index < payload.size()) begin
            @(negedge clock);
            if (buffer_full) begin
                write_enable = 1'b0;
            end else begin
                write_enable = 1'b1;
                write_data   = payload[index];
                write_last   = index == payload.size() - 1;
                index++;
            end
        end
        @(negedge clock);
        write_enable = 1'b0;
        write_last   = 1'b0;
    endtask

    task automatic wait_for_burst();
        while (burst_lengths.size() == 0) begin
            @(negedge clock);
        end
    endtask

    // Expected frame is payload, zero pad to 60 bytes, FCS low byte first
    task automatic check_frame(input byte_queue_t payload);
        byte_queue_t frame;
        logic [31:0] fcs;
        int          length;
        frame = payload;
        while (frame.size() < 60) begin
            frame.push_back(8'h00);
        end
        fcs = reference_fcs(frame);
        for (int i = 0; i < 4; i++) begin
            frame.push_back(fcs[8*i +: 8]);
        end

        wait_for_burst();
        length   = burst_lengths.pop_front();
        last_gap = gap_lengths.pop_front();
        compare_value(length, 8 + frame.size(), "tx_enable burst length");
        for (int i = 0; i < 7; i++) begin
            compare_value(captured_bytes.pop_front(), 8'h55, "preamble byte");
        end
        compare_value(captured_bytes.pop_front(), 8'hD5, "start-of-frame delimiter");
        foreach (frame[i]) begin
            compare_value(captured_bytes.pop_front(), frame[i],
                          $sformatf("frame byte %0d of %0d", i, frame.size()));
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic idle_after_reset();
        wait (reset_n === 1'b1);
        repeat (20) begin
            @(negedge clock);
            compare_value(tx_enable, 1'b0, "tx_enable with nothing written");
            compare_value(buffer_full, 1'b0, "buffer_full with nothing written");
        end
    endtask

    task automatic padded_short_frame();
        byte_queue_t payload;
        payload = random_payload(20);
        write_frame(payload);
        check_frame(payload);
    endtask

    task automatic unpadded_frames();
        byte_queue_t payload;
        payload = random_payload(60);
        write_frame(payload);
        check_frame(payload);
        payload = random_payload(100);
        write_frame(payload);
        check_frame(payload);
    endtask

    // Second frame goes in while the first is on the wire
    task automatic back_to_back_frames();
        byte_queue_t first;
        byte_queue_t second;
        first  = random_payload(30);
        second = random_payload(70);
        write_frame(first);
        write_frame(second);
        check_frame(first);
        check_frame(second);
        compare_value(last_gap >= MIN_GAP, 1'b1, "idle cycles between back-to-back frames");
    endtask

    task automatic full_buffer_frame();
        byte_queue_t payload;
        payload = random_payload(BUFFER_DEPTH);
        write_frame(payload);
        compare_value(buffer_full, 1'b1, "buffer_full after filling the buffer");
        check_frame(payload);
        compare_value(buffer_full, 1'b0, "buffer_full after the frame was sent");
    endtask

    initial begin
        seed         = 32'h91293211;
        error_count  = 0;
        write_data   = '0;
        write_enable = 1'b0;
        write_last   = 1'b0;

        idle_after_reset();
        padded_short_frame();
        unpadded_frames();
        back_to_back_frames();
        full_buffer_frame();

        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Checks failed");
        end
    end

endmodule

`default_nettype wire

//--- build.f
source/ethernet_package.sv
source/payload_buffer.sv
source/transmit_controller.sv
source/frame_check_sequence_generator.sv
source/frame_output_stage.sv
source/ethernet_transmitter.sv
test/clock_generator.sv
test/ethernet_transmitter_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the Ethernet transmitter testbench with Verilator

build_dir=obj_dir
log_file=simulation.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ethernet_transmitter_tb \
    --Mdir "$build_dir" -o ethernet_transmitter_tb \
    -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

"./$build_dir/ethernet_transmitter_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Finished with no errors$" "$log_file"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
